// File: logic/wb_master_pkg.sv
// shared definitions for the Wishbone bus master
//   bus widths and burst length
//   bus-cycle state encoding and requester id
//   address union with a line/word/byte view
//   request struct passed from the arbiter to the state machine

`default_nettype none

package wb_master_pkg;

    // ========================================
    // widths
    // ========================================

    localparam int WB_ADDR_W  = 32;
    localparam int WB_DATA_W  = 32;
    localparam int WB_SEL_W   = 4;

    // words in one cache line fill
    localparam int BURST_LEN  = 4;

    // derived field widths of the address split
    localparam int BYTE_OFF_W = $clog2(WB_SEL_W);
    localparam int WORD_IDX_W = $clog2(BURST_LEN);
    localparam int LINE_TAG_W = WB_ADDR_W - WORD_IDX_W - BYTE_OFF_W;

    // every byte lane enabled, used by all reads
    localparam logic [WB_SEL_W-1:0] SEL_ALL = '1;

    // ========================================
    // types
    // ========================================

    // bus-cycle states, a burst walks BURST1..BURST3 and ends in WAIT_ACK
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        BURST1   = 3'd1,
        BURST2   = 3'd2,
        BURST3   = 3'd3,
        WAIT_ACK = 3'd4
    } wb_state_t;

    // which cache the current transfer belongs to
    typedef enum logic {
        OWNER_ICACHE = 1'b0,
        OWNER_DCACHE = 1'b1
    } req_owner_t;

    // line tag, word within the line and byte lane within the word
    typedef struct packed {
        logic [LINE_TAG_W-1:0] tag;
        logic [WORD_IDX_W-1:0] idx;
        logic [BYTE_OFF_W-1:0] off;
    } wb_addr_fields_t;

    // the same address seen as a flat word or split into its fields
    typedef union packed {
        logic [WB_ADDR_W-1:0] flat;
        wb_addr_fields_t      parts;
    } wb_addr_u;

    // one bus request as formed by the arbiter
    typedef struct packed {
        logic                 we;
        logic                 qword;
        req_owner_t           owner;
        logic [WB_SEL_W-1:0]  sel;
        wb_addr_u             adr;
        logic [WB_DATA_W-1:0] dat;
    } bus_req_t;

endpackage

`default_nettype wire

// File: logic/wb_request_arbiter.sv
// request arbiter for the Wishbone bus master
//   picks the data cache over the instruction cache
//   forms byte select and byte-lane address from the write enables
//   purely combinational, zero cycles of latency

`default_nettype none

module wb_request_arbiter
    import wb_master_pkg::*;
(
    // instruction cache request
    input  logic                 i_icache_req,
    input  logic                 i_icache_qword,
    input  logic [WB_ADDR_W-1:0] i_icache_address,

    // data cache request
    input  logic                 i_dcache_req,
    input  logic                 i_dcache_qword,
    input  logic                 i_dcache_write,
    input  logic [WB_DATA_W-1:0] i_dcache_write_data,
    input  logic [WB_SEL_W-1:0]  i_dcache_byte_enable,
    input  logic [WB_ADDR_W-1:0] i_dcache_address,

    // winning request towards the state machine
    output bus_req_t             o_req,
    output logic                 o_req_valid
);

    logic                  dcache_wr;
    logic [WB_SEL_W-1:0]   sel;
    logic [BYTE_OFF_W-1:0] byte_off;
    wb_addr_u              src_adr;

    // ========================================
    // selection
    // ========================================

    // a write only counts when the data cache is actually asking
    assign dcache_wr = i_dcache_req && i_dcache_write;

    // byte enables only matter for writes, reads always fetch the whole word
    assign sel = dcache_wr ? i_dcache_byte_enable : SEL_ALL;

    // data cache wins whenever both ask in the same cycle
    assign src_adr = i_dcache_req ? i_dcache_address : i_icache_address;

    assign o_req_valid = i_icache_req || i_dcache_req;

    // ========================================
    // byte-lane address
    // ========================================

    // single bytes map to their lane, half words to their lower lane
    // anything else (full word, odd patterns) is sent word aligned
    always_comb
    begin
        case (sel)
            4'b0001: byte_off = 2'd0;
            4'b0010: byte_off = 2'd1;
            4'b0100: byte_off = 2'd2;
            4'b1000: byte_off = 2'd3;
            4'b0011: byte_off = 2'd0;
            4'b1100: byte_off = 2'd2;
            default: byte_off = 2'd0;
        endcase
    end

    // ========================================
    // request assembly
    // ========================================

    always_comb
    begin
        o_req.we    = dcache_wr;
        // a write is always a single word, so its qword flag is dropped
        o_req.qword = i_dcache_req ? (i_dcache_qword && !i_dcache_write) : i_icache_qword;
        o_req.owner = i_dcache_req ? OWNER_DCACHE : OWNER_ICACHE;
        o_req.sel   = sel;
        o_req.adr   = src_adr;
        // instruction fetches see SEL_ALL here and so end up word aligned
        o_req.adr.parts.off = byte_off;
        o_req.dat   = i_dcache_write_data;
    end

endmodule

`default_nettype wire

// File: logic/wb_burst_fsm.sv
// bus-cycle state machine for the Wishbone bus master
//   launches a cycle from IDLE and holds the bus fields until ack
//   steps a wrapping four-word burst through the word index
//   raises the ready pulse of the cache that owns the transfer

`default_nettype none

module wb_burst_fsm
    import wb_master_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 quick_n_reset,

    // request from the arbiter
    input  bus_req_t             i_req,
    input  logic                 i_req_valid,

    // Wishbone slave response
    input  logic                 i_wb_ack,

    // ready pulses back to the caches
    output logic                 o_icache_ready,
    output logic                 o_dcache_ready,

    // Wishbone master outputs
    output logic [WB_ADDR_W-1:0] o_wb_adr,
    output logic [WB_SEL_W-1:0]  o_wb_sel,
    output logic                 o_wb_we,
    output logic [WB_DATA_W-1:0] o_wb_dat,
    output logic                 o_wb_cyc,
    output logic                 o_wb_stb
);

    wb_state_t            state;
    logic                 stb_r;
    logic                 cyc_r;
    logic                 we_r;
    logic [WB_SEL_W-1:0]  sel_r;
    wb_addr_u             adr_r;
    logic [WB_DATA_W-1:0] dat_r;
    req_owner_t           owner_r;

    logic                 launch;
    logic                 bus_ack;
    logic                 read_ack;
    logic                 write_post;

    // ========================================
    // handshake decode
    // ========================================

    // only one transfer at a time, so a new one can only start from IDLE
    assign launch     = (state == IDLE) && i_req_valid;

    // an ack without stb belongs to nobody and is dropped
    assign bus_ack    = i_wb_ack && stb_r;
    assign read_ack   = bus_ack && !we_r;

    // writes are posted, the data cache is released as soon as the write goes out
    assign write_post = launch && i_req.we && (i_req.owner == OWNER_DCACHE);

    // read data rides on i_wb_dat in the same cycle as these pulses
    assign o_icache_ready = read_ack && (owner_r == OWNER_ICACHE);
    assign o_dcache_ready = (read_ack && (owner_r == OWNER_DCACHE)) || write_post;

    // ========================================
    // state and control registers
    // ========================================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state   <= IDLE;
            stb_r   <= 1'b0;
            cyc_r   <= 1'b0;
            we_r    <= 1'b0;
            sel_r   <= '0;
            adr_r   <= '0;
            owner_r <= OWNER_ICACHE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (launch)
                    begin
                        stb_r   <= 1'b1;
                        cyc_r   <= 1'b1;
                        we_r    <= i_req.we;
                        sel_r   <= i_req.sel;
                        adr_r   <= i_req.adr;
                        owner_r <= i_req.owner;
                        // line fills take the burst path, everything else one ack
                        if (i_req.qword && !i_req.we)
                            state <= BURST1;
                        else
                            state <= WAIT_ACK;
                    end
                end

                // each burst ack moves to the next word, wrapping inside the line
                BURST1:
                begin
                    if (bus_ack)
                    begin
                        adr_r.parts.idx <= adr_r.parts.idx + 1'b1;
                        state           <= BURST2;
                    end
                end

                BURST2:
                begin
                    if (bus_ack)
                    begin
                        adr_r.parts.idx <= adr_r.parts.idx + 1'b1;
                        state           <= BURST3;
                    end
                end

                BURST3:
                begin
                    if (bus_ack)
                    begin
                        adr_r.parts.idx <= adr_r.parts.idx + 1'b1;
                        state           <= WAIT_ACK;
                    end
                end

                // last word of a burst, a single read, or a posted write
                WAIT_ACK:
                begin
                    if (bus_ack)
                    begin
                        stb_r <= 1'b0;
                        cyc_r <= 1'b0;
                        we_r  <= 1'b0;
                        state <= IDLE;
                    end
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // write data is only sampled at launch and then held for the slave
    always_ff @(posedge i_clk)
    begin
        if (launch)
            dat_r <= i_req.dat;
    end

    assign o_wb_adr = adr_r.flat;
    assign o_wb_sel = sel_r;
    assign o_wb_we  = we_r;
    assign o_wb_dat = dat_r;
    assign o_wb_cyc = cyc_r;
    assign o_wb_stb = stb_r;

endmodule

`default_nettype wire

// File: logic/a25_wishbone.sv
// top level of the Wishbone bus master
//   request arbiter feeding the bus-cycle state machine
//   read data fanned out to both caches

`default_nettype none

module a25_wishbone
    import wb_master_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 quick_n_reset,

    // instruction cache
    input  logic                 i_icache_req,
    input  logic                 i_icache_qword,
    input  logic [WB_ADDR_W-1:0] i_icache_address,
    output logic [WB_DATA_W-1:0] o_icache_read_data,
    output logic                 o_icache_ready,

    // data cache
    input  logic                 i_dcache_req,
    input  logic                 i_dcache_qword,
    input  logic                 i_dcache_write,
    input  logic [WB_DATA_W-1:0] i_dcache_write_data,
    input  logic [WB_SEL_W-1:0]  i_dcache_byte_enable,
    input  logic [WB_ADDR_W-1:0] i_dcache_address,
    output logic [WB_DATA_W-1:0] o_dcache_read_data,
    output logic                 o_dcache_ready,

    // Wishbone bus
    output logic [WB_ADDR_W-1:0] o_wb_adr,
    output logic [WB_SEL_W-1:0]  o_wb_sel,
    output logic                 o_wb_we,
    input  logic [WB_DATA_W-1:0] i_wb_dat,
    output logic [WB_DATA_W-1:0] o_wb_dat,
    output logic                 o_wb_cyc,
    output logic                 o_wb_stb,
    input  logic                 i_wb_ack
);

    bus_req_t req;
    logic     req_valid;

    wb_request_arbiter u_arbiter (
        .i_icache_req         (i_icache_req),
        .i_icache_qword       (i_icache_qword),
        .i_icache_address     (i_icache_address),
        .i_dcache_req         (i_dcache_req),
        .i_dcache_qword       (i_dcache_qword),
        .i_dcache_write       (i_dcache_write),
        .i_dcache_write_data  (i_dcache_write_data),
        .i_dcache_byte_enable (i_dcache_byte_enable),
        .i_dcache_address     (i_dcache_address),
        .o_req                (req),
        .o_req_valid          (req_valid)
    );

    wb_burst_fsm u_fsm (
        .i_clk          (i_clk),
        .quick_n_reset  (quick_n_reset),
        .i_req          (req),
        .i_req_valid    (req_valid),
        .i_wb_ack       (i_wb_ack),
        .o_icache_ready (o_icache_ready),
        .o_dcache_ready (o_dcache_ready),
        .o_wb_adr       (o_wb_adr),
        .o_wb_sel       (o_wb_sel),
        .o_wb_we        (o_wb_we),
        .o_wb_dat       (o_wb_dat),
        .o_wb_cyc       (o_wb_cyc),
        .o_wb_stb       (o_wb_stb)
    );

    // both caches see the bus data, the ready pulse says whose it is
    assign o_icache_read_data = i_wb_dat;
    assign o_dcache_read_data = i_wb_dat;

endmodule

`default_nettype wire

// File: tests/wb_fsm_assertions.sv
// concurrent checks on the bus-cycle state sequence
//   bound into the state machine by the testbench

`default_nettype none

module wb_fsm_assertions
    import wb_master_pkg::*;
(
    input logic      i_clk,
    input logic      quick_n_reset,
    input wb_state_t i_state,
    input logic      i_bus_ack
);

    // a new cycle either starts a line fill or waits for one ack
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_state == IDLE) |=> (i_state == IDLE || i_state == BURST1 || i_state == WAIT_ACK))
        else $error("IDLE moved to a state other than IDLE, BURST1 or WAIT_ACK");

    // every burst ack moves one word further
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_state == BURST1 && i_bus_ack) |=> (i_state == BURST2))
        else $error("BURST1 did not step to BURST2 on ack");

    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_state == BURST2 && i_bus_ack) |=> (i_state == BURST3))
        else $error("BURST2 did not step to BURST3 on ack");

    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_state == BURST3 && i_bus_ack) |=> (i_state == WAIT_ACK))
        else $error("BURST3 did not step to WAIT_ACK on ack");

    // the last ack of any transfer frees the bus
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_state == WAIT_ACK && i_bus_ack) |=> (i_state == IDLE))
        else $error("WAIT_ACK did not return to IDLE on ack");

endmodule

`default_nettype wire

// File: tests/tb_a25_wishbone.sv
// testbench for the Wishbone bus master
//   random single reads, line fills and posted writes from both caches
//   behavioral slave with random wait states and a write record
//   reference model, per-cycle bus compare and watchdog

`default_nettype none

module tb_a25_wishbone
    import wb_master_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int NUM_REQS   = 300;
    // worst case is five cycles per word plus room for reset and paired requests
    localparam int TIMEOUT    = NUM_REQS * BURST_LEN * 5 * CLK_PERIOD + 60_000;

    // one expected bus transfer that is loaded at launch and stepped on every ack
    typedef struct packed {
        logic                 we;
        logic                 owner_dc;
        logic [WB_SEL_W-1:0]  sel;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat;
        logic [2:0]           words;
    } xfer_t;

    logic                 i_clk;
    logic                 quick_n_reset;
    logic                 i_icache_req;
    logic                 i_icache_qword;
    logic [WB_ADDR_W-1:0] i_icache_address;
    logic [WB_DATA_W-1:0] o_icache_read_data;
    logic                 o_icache_ready;
    logic                 i_dcache_req;
    logic                 i_dcache_qword;
    logic                 i_dcache_write;
    logic [WB_DATA_W-1:0] i_dcache_write_data;
    logic [WB_SEL_W-1:0]  i_dcache_byte_enable;
    logic [WB_ADDR_W-1:0] i_dcache_address;
    logic [WB_DATA_W-1:0] o_dcache_read_data;
    logic                 o_dcache_ready;
    logic [WB_ADDR_W-1:0] o_wb_adr;
    logic [WB_SEL_W-1:0]  o_wb_sel;
    logic                 o_wb_we;
    logic [WB_DATA_W-1:0] i_wb_dat = '0;
    logic [WB_DATA_W-1:0] o_wb_dat;
    logic                 o_wb_cyc;
    logic                 o_wb_stb;
    logic                 i_wb_ack = 1'b0;

    xfer_t                exp_xfer = '0;
    int                   wait_cnt = 0;
    int                   writes_issued = 0;
    logic [WB_DATA_W-1:0] write_log[$];

    a25_wishbone dut (.*);

    bind wb_burst_fsm wb_fsm_assertions u_fsm_assertions (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_state       (state),
        .i_bus_ack     (bus_ack)
    );

    // ========================================
    // reference model
    // ========================================

    // slave memory contents are a fixed scramble of the word address
    function automatic logic [31:0] scramble_word(input logic [31:0] adr);
        logic [31:0] word;
        word = {2'b00, adr[31:2]};
        return (word * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
    endfunction

    // expected transfer for the cache inputs of a launch cycle
    function automatic xfer_t predict_transfer();
        xfer_t      x;
        logic [1:0] off;
        // the data cache always wins, and only it can write
        x.owner_dc = i_dcache_req;
        x.we       = i_dcache_req && i_dcache_write;
        x.sel      = x.we ? i_dcache_byte_enable : 4'hF;
        // single lanes and aligned half words point at their lowest lane
        case (x.sel)
            4'b0010: off = 2'd1;
            4'b0100: off = 2'd2;
            4'b1100: off = 2'd2;
            4'b1000: off = 2'd3;
            default: off = 2'd0;
        endcase
        x.adr = {(i_dcache_req ? i_dcache_address[31:2] : i_icache_address[31:2]), off};
        x.dat = i_dcache_write_data;
        if (!x.we && (i_dcache_req ? i_dcache_qword : i_icache_qword))
            x.words = 3'(BURST_LEN);
        else
            x.words = 3'd1;
        return x;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        report_failure($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // drive one request from either or both caches and hold each until its last ready
    task automatic run_request(input logic use_ic, input logic use_dc);
        int   ic_left;
        int   dc_left;
        logic ic_qw;
        logic dc_qw;
        logic dc_wr;
        ic_qw   = 1'($urandom_range(0, 1));
        dc_qw   = 1'($urandom_range(0, 1));
        dc_wr   = 1'($urandom_range(0, 1));
        ic_left = !use_ic ? 0 : (ic_qw ? BURST_LEN : 1);
        dc_left = !use_dc ? 0 : ((dc_qw && !dc_wr) ? BURST_LEN : 1);
        // every write asked for here has to reach the slave exactly once
        if (use_dc && dc_wr)
            writes_issued = writes_issued + 1;
        i_icache_req         <= use_ic;
        i_icache_qword       <= ic_qw;
        i_icache_address     <= $urandom & 32'hFFFF_FFFC;
        i_dcache_req         <= use_dc;
        i_dcache_qword       <= dc_qw;
        i_dcache_write       <= dc_wr;
        i_dcache_write_data  <= $urandom;
        i_dcache_byte_enable <= 4'($urandom_range(0, 15));
        i_dcache_address     <= $urandom;
        while (ic_left > 0 || dc_left > 0)
        begin
            @(posedge i_clk);
            if (o_icache_ready && ic_left > 0)
            begin
                ic_left = ic_left - 1;
                if (ic_left == 0)
                    i_icache_req <= 1'b0;
            end
            if (o_dcache_ready && dc_left > 0)
            begin
                dc_left = dc_left - 1;
                if (dc_left == 0)
                    i_dcache_req <= 1'b0;
            end
        end
    endtask

    // ========================================
    // clock, slave and watchdog
    // ========================================

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial
    begin
        #(TIMEOUT);
        report_failure("watchdog expired before all requests completed");
    end

    // acks each stb after 0 to 3 wait cycles and keeps every write it accepts
    always @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            i_wb_ack <= 1'b0;
            wait_cnt <= 0;
        end
        else if (i_wb_ack)
        begin
            i_wb_ack <= 1'b0;
            wait_cnt <= $urandom_range(0, 3);
        end
        else if (o_wb_stb)
        begin
            if (wait_cnt == 0)
            begin
                i_wb_ack <= 1'b1;
                i_wb_dat <= scramble_word(o_wb_adr);
                if (o_wb_we)
                    write_log.push_back(o_wb_dat);
            end
            else
            begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    // ========================================
    // compare
    // ========================================

    always @(posedge i_clk)
    begin : compare
        logic        exp_ic_rdy;
        logic        exp_dc_rdy;
        logic        launch;
        logic [31:0] rd;
        if (quick_n_reset)
        begin
            exp_ic_rdy = 1'b0;
            exp_dc_rdy = 1'b0;
            // cyc is low only in IDLE, so any held request launches here
            launch = !o_wb_cyc && (i_icache_req || i_dcache_req);
            assert (o_wb_stb == (exp_xfer.words != 0) && o_wb_cyc == o_wb_stb)
                else report_failure("stb or cyc does not match the expected bus activity");
            if (exp_xfer.words != 0)
            begin
                // fields must hold still until ack and follow the expected transfer
                assert (o_wb_adr == exp_xfer.adr)
                    else report_mismatch("o_wb_adr", o_wb_adr, exp_xfer.adr);
                assert (o_wb_sel == exp_xfer.sel)
                    else report_mismatch("o_wb_sel", 32'(o_wb_sel), 32'(exp_xfer.sel));
                assert (o_wb_we == exp_xfer.we)
                    else report_mismatch("o_wb_we", 32'(o_wb_we), 32'(exp_xfer.we));
                if (exp_xfer.we)
                begin
                    assert (o_wb_dat == exp_xfer.dat)
                        else report_mismatch("o_wb_dat", o_wb_dat, exp_xfer.dat);
                end
                if (i_wb_ack)
                begin
                    // a read ack brings the owner's ready pulse and its data
                    if (!exp_xfer.we)
                    begin
                        exp_ic_rdy = !exp_xfer.owner_dc;
                        exp_dc_rdy = exp_xfer.owner_dc;
                        rd = exp_xfer.owner_dc ? o_dcache_read_data : o_icache_read_data;
                        assert (rd == scramble_word(exp_xfer.adr))
                            else report_mismatch(exp_xfer.owner_dc ? "o_dcache_read_data"
                                : "o_icache_read_data", rd, scramble_word(exp_xfer.adr));
                    end
                    // the word index wraps inside the line while tag and lane stay put
                    exp_xfer.adr[3:2] = exp_xfer.adr[3:2] + 2'd1;
                    exp_xfer.words = exp_xfer.words - 3'd1;
                end
            end
            if (launch)
            begin
                exp_xfer = predict_transfer();
                // a posted write releases the data cache in the launch cycle
                exp_dc_rdy = exp_xfer.we;
            end
            assert (o_icache_ready == exp_ic_rdy)
                else report_mismatch("o_icache_ready", 32'(o_icache_ready), 32'(exp_ic_rdy));
            assert (o_dcache_ready == exp_dc_rdy)
                else report_mismatch("o_dcache_ready", 32'(o_dcache_ready), 32'(exp_dc_rdy));
        end
    end

    // ========================================
    // main sequence
    // ========================================

    initial
    begin
        int issued;
        int kind;
        void'($urandom(9));
        quick_n_reset        = 1'b0;
        i_icache_req         = 1'b0;
        i_icache_qword       = 1'b0;
        i_icache_address     = '0;
        i_dcache_req         = 1'b0;
        i_dcache_qword       = 1'b0;
        i_dcache_write       = 1'b0;
        i_dcache_write_data  = '0;
        i_dcache_byte_enable = '0;
        i_dcache_address     = '0;
        repeat (10) @(posedge i_clk);
        assert (!o_wb_stb && !o_wb_cyc && !o_wb_we && !o_icache_ready && !o_dcache_ready)
            else report_failure("a bus or ready output is active after reset");
        assert (o_wb_sel == '0) else report_mismatch("o_wb_sel", 32'(o_wb_sel), 32'h0);
        assert (o_wb_adr == '0) else report_mismatch("o_wb_adr", o_wb_adr, 32'h0);
        quick_n_reset <= 1'b1;
        issued = 0;
        // kind 0 is the icache alone, 1 the dcache alone, 2 both at once
        while (issued < NUM_REQS)
        begin
            kind = $urandom_range(0, 2);
            @(posedge i_clk);
            run_request(kind != 1, kind != 0);
            issued = issued + ((kind == 2) ? 2 : 1);
        end
        // a posted write may still be waiting for its ack
        while (o_wb_cyc)
        begin
            @(posedge i_clk);
        end
        repeat (2) @(posedge i_clk);
        if (write_log.size() == writes_issued)
        begin
            $display("Regression passed");
            $finish;
        end
        else
        begin
            report_failure("slave write count differs from the writes the data cache issued");
        end
    end

endmodule

`default_nettype wire

// File: sources.f
logic/wb_master_pkg.sv
logic/wb_request_arbiter.sv
logic/wb_burst_fsm.sv
logic/a25_wishbone.sv
tests/wb_fsm_assertions.sv
tests/tb_a25_wishbone.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_a25_wishbone
FILELIST   ?= sources.f
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || { echo "simulation ended early"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
